// File: flist.f
+incdir+include
src/icache_pkg.sv
src/icache_way_ram.sv
src/icache_fetch_pipe.sv
src/icache_refill_ctrl.sv
src/icache_top.sv
verif/icache_l2_model.sv
verif/icache_tb.sv

// File: include/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Address and word geometry
////////////////////////////////////////////////////////////////////////////
`define ICACHE_ADDR_W           32
`define ICACHE_WORD_W           32

////////////////////////////////////////////////////////////////////////////
// Block and set geometry, 64 sets of 16 words per way
////////////////////////////////////////////////////////////////////////////
`define ICACHE_WORDS_PER_BLOCK  16
`define ICACHE_BYTE_SEL_W       2
`define ICACHE_WORD_SEL_W       4
`define ICACHE_SETS             64
`define ICACHE_SET_W            6

`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_SET_W - `ICACHE_WORD_SEL_W - `ICACHE_BYTE_SEL_W)
`define ICACHE_BLOCK_W  (`ICACHE_WORD_W * `ICACHE_WORDS_PER_BLOCK)

`endif

// File: src/icache_fetch_pipe.sv
`include "icache_defs.svh"

module icache_fetch_pipe (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  logic                        stall,
    input  icache_pkg::fetch_addr_u     pc,
    input  logic                        pc_valid,
    input  logic                        cache_ready,
    input  icache_pkg::way_lookup_t     lookup0,
    input  icache_pkg::way_lookup_t     lookup1,
    input  icache_pkg::block_t          block0,
    input  icache_pkg::block_t          block1,
    input  logic                        fill_done,
    input  icache_pkg::block_t          fill_block,
    output logic [`ICACHE_SET_W-1:0]    rd_set,
    output logic                        advance,
    output icache_pkg::hit_info_t       hit_info,
    output icache_pkg::block_addr_t     miss_addr,
    output logic [`ICACHE_WORD_W-1:0]   instruction,
    output logic                        instr_valid
);

    import icache_pkg::*;

    fetch_addr_u                if2_pc;
    logic                       if2_valid;
    fetch_addr_u                if3_pc;
    logic                       if3_valid;
    logic                       if3_hit0;
    logic                       if3_hit1;
    block_t                     if3_block;

    logic                       hit0_if2;
    logic                       hit1_if2;
    logic [`ICACHE_WORD_W-1:0]  word_if3;
    logic [`ICACHE_WORD_W-1:0]  instr_q;
    logic                       instr_valid_q;

    // Whole pipe moves unless held; a fetch enters only with pc_valid
    assign advance = cache_ready && !stall;

    // Held pipe keeps re-reading the IF2 set
    assign rd_set = advance ? pc.f.set : if2_pc.f.set;

    ////////////////////////////////////////////////////////////////////////////
    // IF2 tag compare
    ////////////////////////////////////////////////////////////////////////////
    assign hit0_if2 = lookup0.valid && (lookup0.tag == if2_pc.f.tag);
    assign hit1_if2 = lookup1.valid && (lookup1.tag == if2_pc.f.tag);

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            if2_pc        <= '0;
            if2_valid     <= 1'b0;
            if3_pc        <= '0;
            if3_valid     <= 1'b0;
            if3_hit0      <= 1'b0;
            if3_hit1      <= 1'b0;
            instr_valid_q <= 1'b0;
        end
        else if (advance)
        begin
            if2_pc        <= pc;
            if2_valid     <= pc_valid;
            if3_pc        <= if2_pc;
            if3_valid     <= if2_valid;
            if3_hit0      <= if2_valid && hit0_if2;
            if3_hit1      <= if2_valid && hit1_if2;
            instr_valid_q <= if3_valid;
        end
        else
        begin
            instr_valid_q <= 1'b0;
            // Refilled entry now counts as present
            if (fill_done)
                if3_hit0 <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // IF3 block and instruction register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            if3_block <= hit1_if2 ? block1 : block0;
            instr_q   <= word_if3;
        end
        else if (fill_done)
        begin
            if3_block <= fill_block;
        end
    end

    assign word_if3 = if3_block[if3_pc.f.word * `ICACHE_WORD_W +: `ICACHE_WORD_W];

    // Block address is the top of the raw PC
    assign miss_addr = if3_pc.raw[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W + `ICACHE_SET_W];

    assign hit_info = '{
        valid: if3_valid,
        hit0:  if3_hit0,
        hit1:  if3_hit1,
        set:   if3_pc.f.set
    };

    assign instruction = instr_q;
    assign instr_valid = instr_valid_q;

    // A held miss keeps its address until it retires
    a_miss_held: assert property (@(posedge CLK) disable iff (!arst_n)
        (if3_valid && !if3_hit0 && !if3_hit1) |=> $stable(if3_pc));

endmodule

// File: src/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

    // Field view of a fetch address
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]      tag;
        logic [`ICACHE_SET_W-1:0]      set;
        logic [`ICACHE_WORD_SEL_W-1:0] word;
        logic [`ICACHE_BYTE_SEL_W-1:0] byte_off;
    } fetch_fields_t;

    // Same fetch word, raw or split into fields
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        fetch_fields_t             f;
    } fetch_addr_u;

    // Names one block towards L2
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
        logic [`ICACHE_SET_W-1:0] set;
    } block_addr_t;

    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } way_lookup_t;

    // Refill write command
    typedef struct packed {
        logic                     we0;
        logic                     we1;
        logic [`ICACHE_SET_W-1:0] set;
    } fill_t;

    typedef struct packed {
        logic                     valid;
        logic                     hit0;
        logic                     hit1;
        logic [`ICACHE_SET_W-1:0] set;
    } hit_info_t;

    // Word 0 sits in the low bits
    typedef logic [`ICACHE_BLOCK_W-1:0] block_t;

endpackage

// File: src/icache_refill_ctrl.sv
`include "icache_defs.svh"

module icache_refill_ctrl (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  icache_pkg::hit_info_t       hit_info,
    input  logic                        advance,
    input  icache_pkg::block_addr_t     miss_addr,
    output logic                        cache_ready,
    output icache_pkg::fill_t           fill,
    output icache_pkg::block_t          fill_block,
    output logic                        fill_done,
    output icache_pkg::block_addr_t     l2_addr,
    output logic                        l2_addr_valid,
    input  logic                        l2_addr_ready,
    output logic                        l2_data_ready,
    input  logic                        l2_data_valid,
    input  icache_pkg::block_t          l2_data
);

    import icache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        WAIT_DATA,
        FILL,
        RESUME
    } state_t;

    state_t                     state_q;
    logic [`ICACHE_SETS-1:0]    lru_q;
    logic                       refilled_q;
    logic                       l2_addr_valid_q;
    logic                       l2_data_ready_q;
    block_addr_t                l2_addr_q;
    block_t                     fill_block_q;

    logic                       miss;
    logic                       in_fill;
    logic                       victim;

    assign miss    = hit_info.valid && !hit_info.hit0 && !hit_info.hit1;
    assign in_fill = (state_q == FILL);
    // LRU bit names the way to replace
    assign victim  = lru_q[hit_info.set];

    assign cache_ready = (state_q == IDLE) && !miss;

    ////////////////////////////////////////////////////////////////////////////
    // Miss FSM and LRU bits
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q         <= IDLE;
            lru_q           <= '0;
            refilled_q      <= 1'b0;
            l2_addr_valid_q <= 1'b0;
            l2_data_ready_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    if (miss)
                    begin
                        state_q         <= REQ;
                        l2_addr_valid_q <= 1'b1;
                    end
                    else if (advance)
                    begin
                        refilled_q <= 1'b0;
                        // Refilled entry already set its bit in FILL
                        if (hit_info.valid && !refilled_q)
                        begin
                            if (hit_info.hit0)
                                lru_q[hit_info.set] <= 1'b1;
                            else if (hit_info.hit1)
                                lru_q[hit_info.set] <= 1'b0;
                        end
                    end
                end
                REQ:
                begin
                    if (l2_addr_ready)
                    begin
                        l2_addr_valid_q <= 1'b0;
                        l2_data_ready_q <= 1'b1;
                        state_q         <= WAIT_DATA;
                    end
                end
                WAIT_DATA:
                begin
                    if (l2_data_valid && l2_data_ready_q)
                    begin
                        l2_data_ready_q <= 1'b0;
                        state_q         <= FILL;
                    end
                end
                FILL:
                begin
                    lru_q[hit_info.set] <= !victim;
                    state_q             <= RESUME;
                end
                RESUME:
                begin
                    refilled_q <= 1'b1;
                    state_q    <= IDLE;
                end
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    // Request address and returned block
    always_ff @(posedge CLK)
    begin
        if (state_q == IDLE && miss)
            l2_addr_q <= miss_addr;
        if (state_q == WAIT_DATA && l2_data_valid && l2_data_ready_q)
            fill_block_q <= l2_data;
    end

    assign fill = '{we0: in_fill && !victim, we1: in_fill && victim, set: hit_info.set};

    assign fill_block    = fill_block_q;
    assign fill_done     = (state_q == RESUME);
    assign l2_addr       = l2_addr_q;
    assign l2_addr_valid = l2_addr_valid_q;
    assign l2_data_ready = l2_data_ready_q;

    a_addr_stable: assert property (@(posedge CLK) disable iff (!arst_n)
        (l2_addr_valid && !l2_addr_ready) |=> (l2_addr_valid && $stable(l2_addr)));

    // Refill goes to the set of the still pending miss
    a_fill_pending_set: assert property (@(posedge CLK) disable iff (!arst_n)
        (fill.we0 || fill.we1) |-> (miss && fill.set == l2_addr.set));

endmodule

// File: src/icache_top.sv
`include "icache_defs.svh"

module icache_top (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  logic                        stall,
    input  icache_pkg::fetch_addr_u     pc,
    input  logic                        pc_valid,
    output logic [`ICACHE_WORD_W-1:0]   instruction,
    output logic                        instr_valid,
    output logic                        cache_ready,
    output icache_pkg::block_addr_t     l2_addr,
    output logic                        l2_addr_valid,
    input  logic                        l2_addr_ready,
    output logic                        l2_data_ready,
    input  logic                        l2_data_valid,
    input  icache_pkg::block_t          l2_data
);

    import icache_pkg::*;

    logic [`ICACHE_SET_W-1:0]   rd_set;
    logic                       advance;
    way_lookup_t                lookup0;
    way_lookup_t                lookup1;
    block_t                     block0;
    block_t                     block1;
    fill_t                      fill;
    block_t                     fill_block;
    logic                       fill_done;
    hit_info_t                  hit_info;
    block_addr_t                miss_addr;

    icache_way_ram #(.way_index(0)) way0 (
        .CLK(CLK), .arst_n(arst_n), .rd_set(rd_set), .fill(fill),
        .fill_tag(miss_addr.tag), .fill_block(fill_block),
        .lookup(lookup0), .block(block0)
    );

    icache_way_ram #(.way_index(1)) way1 (
        .CLK(CLK), .arst_n(arst_n), .rd_set(rd_set), .fill(fill),
        .fill_tag(miss_addr.tag), .fill_block(fill_block),
        .lookup(lookup1), .block(block1)
    );

    icache_fetch_pipe fetch_pipe0 (
        .CLK(CLK), .arst_n(arst_n), .stall(stall), .pc(pc), .pc_valid(pc_valid),
        .cache_ready(cache_ready), .lookup0(lookup0), .lookup1(lookup1),
        .block0(block0), .block1(block1), .fill_done(fill_done), .fill_block(fill_block),
        .rd_set(rd_set), .advance(advance), .hit_info(hit_info), .miss_addr(miss_addr),
        .instruction(instruction), .instr_valid(instr_valid)
    );

    icache_refill_ctrl refill_ctrl0 (
        .CLK(CLK), .arst_n(arst_n), .hit_info(hit_info), .advance(advance),
        .miss_addr(miss_addr), .cache_ready(cache_ready), .fill(fill),
        .fill_block(fill_block), .fill_done(fill_done),
        .l2_addr(l2_addr), .l2_addr_valid(l2_addr_valid), .l2_addr_ready(l2_addr_ready),
        .l2_data_ready(l2_data_ready), .l2_data_valid(l2_data_valid), .l2_data(l2_data)
    );

endmodule

// File: src/icache_way_ram.sv
`include "icache_defs.svh"

module icache_way_ram #(
    parameter int way_index = 0
) (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  logic [`ICACHE_SET_W-1:0]    rd_set,
    input  icache_pkg::fill_t           fill,
    input  logic [`ICACHE_TAG_W-1:0]    fill_tag,
    input  icache_pkg::block_t          fill_block,
    output icache_pkg::way_lookup_t     lookup,
    output icache_pkg::block_t          block
);

    import icache_pkg::*;

    logic [`ICACHE_SETS-1:0]    valid_q;
    logic [`ICACHE_TAG_W-1:0]   tag_mem [`ICACHE_SETS];
    block_t                     data_mem [`ICACHE_SETS];

    logic                       rd_valid_q;
    logic [`ICACHE_TAG_W-1:0]   rd_tag_q;
    block_t                     rd_block_q;
    logic                       wr_en;

    // Pick this way's enable out of the shared command
    assign wr_en = (way_index == 0) ? fill.we0 : fill.we1;

    ////////////////////////////////////////////////////////////////////////////
    // Valid bits
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end
        else
        begin
            if (wr_en)
                valid_q[fill.set] <= 1'b1;
            rd_valid_q <= valid_q[rd_set];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tag and data arrays, read before write
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (wr_en)
        begin
            tag_mem[fill.set]  <= fill_tag;
            data_mem[fill.set] <= fill_block;
        end
        rd_tag_q   <= tag_mem[rd_set];
        rd_block_q <= data_mem[rd_set];
    end

    assign lookup = '{valid: rd_valid_q, tag: rd_tag_q};
    assign block  = rd_block_q;

    // Only one way takes a refill
    a_one_way_fill: assert property (@(posedge CLK) disable iff (!arst_n)
        !(fill.we0 && fill.we1));

endmodule

// File: verif/icache_l2_model.sv
`include "icache_defs.svh"

module icache_l2_model (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  icache_pkg::block_addr_t     l2_addr,
    input  logic                        l2_addr_valid,
    output logic                        l2_addr_ready,
    input  logic                        l2_data_ready,
    output logic                        l2_data_valid,
    output icache_pkg::block_t          l2_data,
    output int                          req_count,
    output int                          unstable_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    // Accepted block addresses in arrival order
    block_addr_t    req_q[$];

    // Word at byte address a is a with the low bits cleared, XOR 9E3779B9
    function automatic block_t make_block(input block_addr_t ba);
        block_t blk;
        int     i;
        for (i = 0; i < `ICACHE_WORDS_PER_BLOCK; i++)
            blk[i*`ICACHE_WORD_W +: `ICACHE_WORD_W] = {ba, 4'(i), 2'b00} ^ 32'h9E3779B9;
        return blk;
    endfunction

    initial
    begin
        block_addr_t    held;
        int             wait_cycles;
        l2_addr_ready  = 1'b0;
        l2_data_valid  = 1'b0;
        l2_data        = '0;
        req_count      = 0;
        unstable_count = 0;
        forever
        begin
            @(negedge CLK);
            if (arst_n && l2_addr_valid)
            begin
                held        = l2_addr;
                wait_cycles = $urandom_range(0, 5);
                repeat (wait_cycles)
                begin
                    @(negedge CLK);
                    if (!l2_addr_valid || l2_addr != held)
                        unstable_count++;
                end
                // Transfer on the next rising edge
                l2_addr_ready = 1'b1;
                req_q.push_back(held);
                req_count++;
                @(negedge CLK);
                l2_addr_ready = 1'b0;
                wait_cycles   = $urandom_range(1, 8);
                repeat (wait_cycles - 1)
                    @(negedge CLK);
                l2_data       = make_block(held);
                l2_data_valid = 1'b1;
                while (!l2_data_ready)
                    @(negedge CLK);
                @(negedge CLK);
                l2_data_valid = 1'b0;
            end
        end
    end

endmodule

// File: verif/icache_tb.sv
`include "icache_defs.svh"

module icache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    logic                       CLK;
    logic                       arst_n;
    logic                       stall;
    fetch_addr_u                pc;
    logic                       pc_valid;
    logic [`ICACHE_WORD_W-1:0]  instruction;
    logic                       instr_valid;
    logic                       cache_ready;
    block_addr_t                l2_addr;
    logic                       l2_addr_valid;
    logic                       l2_addr_ready;
    logic                       l2_data_ready;
    logic                       l2_data_valid;
    block_t                     l2_data;
    int                         req_count;
    int                         unstable_count;

    // Whole fetch stream, split into tests by test_end
    logic [`ICACHE_ADDR_W-1:0]  addr_list[$];
    int                         test_end[7];
    int                         exp_miss[7];
    block_addr_t                exp_req[$];

    // Reference tag store
    logic [`ICACHE_TAG_W-1:0]   ref_tag[2][`ICACHE_SETS];
    logic                       ref_vld[2][`ICACHE_SETS];
    logic                       ref_lru[`ICACHE_SETS];

    logic [`ICACHE_ADDR_W-1:0]  exp_q[$];
    int                         acc_q[$];
    int                         cyc = 0;
    int                         cyc_limit = 0;
    int                         err_count = 0;
    int                         tests_failed = 0;
    int                         req_base = 0;
    int                         exp_base = 0;
    int                         unstable_base = 0;
    bit                         latency_check = 1'b0;

    icache_top dut0 (.*);

    icache_l2_model l2_model0 (.*);

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [`ICACHE_WORD_W-1:0] expected_instr(
        input logic [`ICACHE_ADDR_W-1:0] a);
        return {a[`ICACHE_ADDR_W-1:2], 2'b00} ^ 32'h9E3779B9;
    endfunction

    // Two ways per set, LRU bit names the way to replace; 1 on a miss
    function automatic bit ref_access(input logic [`ICACHE_ADDR_W-1:0] a);
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_SET_W-1:0]   idx;
        bit                         way;
        bit                         miss;
        tag  = a[31:12];
        idx  = a[11:6];
        miss = 1'b0;
        if (ref_vld[0][idx] && ref_tag[0][idx] == tag)
            ref_lru[idx] = 1'b1;
        else if (ref_vld[1][idx] && ref_tag[1][idx] == tag)
            ref_lru[idx] = 1'b0;
        else
        begin
            way               = ref_lru[idx];
            ref_vld[way][idx] = 1'b1;
            ref_tag[way][idx] = tag;
            ref_lru[idx]      = !way;
            miss              = 1'b1;
        end
        return miss;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("error %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before)
            $display("test %0d %s: ok", num, name);
        else
        begin
            $display("test %0d %s: %0d failed checks", num, name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Fetch stream and expected L2 requests
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_stream();
        logic [`ICACHE_ADDR_W-1:0]  blk[6];
        int                         i;
        int                         t;
        blk = '{32'h0000_1000, 32'h0000_1040, 32'h0000_1080,
                32'h0001_01C0, 32'h0002_01C0, 32'h0003_01C0};
        for (i = 0; i < `ICACHE_SETS; i++)
        begin
            ref_vld[0][i] = 1'b0;
            ref_vld[1][i] = 1'b0;
            ref_lru[i]    = 1'b0;
        end
        test_end[0] = 0;
        test_end[1] = 0;
        // Three consecutive blocks, fetched twice
        for (t = 2; t <= 3; t++)
        begin
            for (i = 0; i < 48; i++)
                addr_list.push_back(32'h0000_1000 + 4 * i);
            test_end[t] = addr_list.size();
        end
        // A, B and C share set 7
        addr_list.push_back(blk[3]);
        addr_list.push_back(blk[4]);
        addr_list.push_back(blk[3] + 4);
        addr_list.push_back(blk[5]);
        addr_list.push_back(blk[3] + 8);
        addr_list.push_back(blk[4] + 4);
        test_end[4] = addr_list.size();
        for (i = 0; i < 64; i++)
            addr_list.push_back(blk[$urandom_range(0, 5)] + 4 * $urandom_range(0, 15));
        test_end[5] = addr_list.size();
        // Eight tags over sets 3 and 4
        for (i = 0; i < 32; i++)
            addr_list.push_back({20'h00040 + 20'($urandom_range(0, 7)),
                                 6'(3 + $urandom_range(0, 1)),
                                 4'($urandom_range(0, 15)), 2'b00});
        test_end[6] = addr_list.size();
        for (t = 1; t <= 6; t++)
        begin
            exp_miss[t] = 0;
            for (i = test_end[t-1]; i < test_end[t]; i++)
            begin
                if (ref_access(addr_list[i]))
                begin
                    exp_miss[t]++;
                    exp_req.push_back(addr_list[i][`ICACHE_ADDR_W-1:6]);
                end
            end
        end
    endtask

    task automatic run_test(input int num, input string name, input bit use_stall,
                            input bit check_lat);
        int errs_before;
        int i;
        int k;
        errs_before   = err_count;
        latency_check = check_lat;
        i = test_end[num-1];
        while (i < test_end[num])
        begin
            @(negedge CLK);
            stall    = use_stall && ($urandom_range(0, 3) == 0);
            pc.raw   = addr_list[i];
            pc_valid = 1'b1;
            // Taken on the next rising edge
            if (cache_ready && !stall)
            begin
                exp_q.push_back(addr_list[i]);
                acc_q.push_back(cyc);
                i++;
            end
        end
        @(negedge CLK);
        pc_valid = 1'b0;
        stall    = 1'b0;
        while (exp_q.size() != 0)
            @(negedge CLK);
        latency_check = 1'b0;
        check_value("req_count", req_count - req_base, exp_miss[num]);
        if (req_count - req_base == exp_miss[num])
        begin
            for (k = 0; k < exp_miss[num]; k++)
                check_value("l2_addr", l2_model0.req_q[req_base + k], exp_req[exp_base + k]);
        end
        assert (unstable_count == unstable_base)
        else
        begin
            $display("l2_addr changed or l2_addr_valid dropped before l2_addr_ready");
            err_count++;
        end
        req_base      = req_count;
        exp_base      = exp_base + exp_miss[num];
        unstable_base = unstable_count;
        report_test(num, name, errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Returned instructions against the queued fetches
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge CLK)
    begin
        logic [`ICACHE_ADDR_W-1:0]  a;
        int                         t;
        if (instr_valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("instruction returned with no fetch outstanding");
                err_count++;
            end
            if (exp_q.size() != 0)
            begin
                a = exp_q.pop_front();
                t = acc_q.pop_front();
                check_value($sformatf("instruction for pc %h", a), instruction,
                            expected_instr(a));
                if (latency_check)
                begin
                    assert (cyc - t == 3)
                    else
                    begin
                        $display("instruction for pc %h took %0d cycles instead of 3",
                                 a, cyc - t);
                        err_count++;
                    end
                end
            end
        end
    end

    always @(posedge CLK)
    begin
        cyc = cyc + 1;
        if (cyc > cyc_limit)
        begin
            $display("timeout after %0d cycles with %0d fetches outstanding",
                     cyc, exp_q.size());
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(91));
        arst_n   = 1'b0;
        stall    = 1'b0;
        pc       = '0;
        pc_valid = 1'b0;
        build_stream();
        cyc_limit = 20 * addr_list.size() + 60 * exp_req.size();
        repeat (10) @(negedge CLK);
        arst_n = 1'b1;
        @(negedge CLK);
        check_value("cache_ready", cache_ready, 1);
        check_value("instr_valid", instr_valid, 0);
        check_value("l2_addr_valid", l2_addr_valid, 0);
        check_value("l2_data_ready", l2_data_ready, 0);
        report_test(1, "idle outputs after reset", 0);
        run_test(2, "cold sequential fetch", 1'b0, 1'b0);
        run_test(3, "warm refetch", 1'b0, 1'b1);
        run_test(4, "LRU replacement in one set", 1'b0, 1'b0);
        run_test(5, "random stall", 1'b1, 1'b0);
        run_test(6, "conflict misses under L2 delay", 1'b0, 1'b0);
        $display("tests run 6, tests failed %0d, failed checks %0d", tests_failed, err_count);
        if (err_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
